// ==== verilog/rdma_resp_gen_pkg.sv ====
package rdma_resp_gen_pkg;

  // packet geometry
  localparam int HDR_BYTES        = 58;
  localparam int RD_PAYLOAD_BYTES = 256;
  localparam int RD_PKT_BYTES     = HDR_BYTES + RD_PAYLOAD_BYTES;
  localparam int ACK_PKT_BYTES    = HDR_BYTES;  // header only
  localparam int BEAT_BYTES       = 64;
  localparam int MAX_BEATS        = 5;

  typedef logic [MAX_BEATS*BEAT_BYTES*8-1:0] pkt_vec_t;  // byte 0 in lane 0
  typedef logic [HDR_BYTES*8-1:0]            hdr_vec_t;
  typedef logic [8:0]                        pkt_len_t;  // up to RD_PKT_BYTES

  typedef enum logic {
    PKT_RD_RESP = 1'b0,
    PKT_ACK     = 1'b1
  } pkt_kind_e;

  typedef logic [23:0] qpn_t;
  typedef logic [23:0] psn_t;
  typedef logic [47:0] mac_t;
  typedef logic [31:0] ipv4_t;

  // ethernet / ipv4
  localparam logic [15:0] ETH_TYPE_IPV4    = 16'h0800;
  localparam logic [7:0]  IP_VER_IHL       = 8'h45;
  localparam logic [7:0]  IP_TOS           = 8'hb8;
  localparam logic [15:0] IP_ID            = 16'h5555;
  localparam logic [15:0] IP_FLAGS         = 16'h4000;  // don't fragment
  localparam logic [7:0]  IP_TTL           = 8'hba;
  localparam logic [7:0]  IP_PROTO_UDP     = 8'h11;
  localparam logic [15:0] IP_TOTAL_LEN_RD  = 16'h0130;  // includes icrc
  localparam logic [15:0] IP_TOTAL_LEN_ACK = 16'h0030;

  // udp / bth
  localparam logic [15:0] UDP_SRC_PORT     = 16'h6851;
  localparam logic [15:0] UDP_DST_PORT     = 16'h12b7;  // rocev2
  localparam logic [7:0]  BTH_OPC_RD_RESP  = 8'h10;     // rd resp only
  localparam logic [7:0]  BTH_OPC_ACK      = 8'h11;
  localparam logic [15:0] BTH_PKEY         = 16'h666f;
  localparam logic [7:0]  BTH_RSVD         = 8'h05;

  // peer used when the qp is not in the table
  localparam logic [47:0] DEFAULT_PEER_MAC = 48'h16c450560f2e;
  localparam logic [31:0] DEFAULT_PEER_IP  = 32'h610c6007;

endpackage

// ==== verilog/ipv4_hdr_checksum.sv ====
`timescale 1ns/1ps

module ipv4_hdr_checksum (
  input  logic [15:0]              total_len_i,
  input  rdma_resp_gen_pkg::ipv4_t dst_ip_i,
  input  rdma_resp_gen_pkg::ipv4_t src_ip_i,
  output logic [15:0]              csum_o
);

  logic [19:0] sum;
  logic [16:0] fold1;
  logic [15:0] fold2;

  // checksum field itself counts as zero
  always_comb begin
    sum = {4'h0, rdma_resp_gen_pkg::IP_VER_IHL, rdma_resp_gen_pkg::IP_TOS}
        + {4'h0, total_len_i}
        + {4'h0, rdma_resp_gen_pkg::IP_ID}
        + {4'h0, rdma_resp_gen_pkg::IP_FLAGS}
        + {4'h0, rdma_resp_gen_pkg::IP_TTL, rdma_resp_gen_pkg::IP_PROTO_UDP}
        + {4'h0, src_ip_i[31:16]}
        + {4'h0, src_ip_i[15:0]}
        + {4'h0, dst_ip_i[31:16]}
        + {4'h0, dst_ip_i[15:0]};
  end

  assign fold1  = {1'b0, sum[15:0]} + {13'd0, sum[19:16]};
  // second fold cannot carry again
  assign fold2  = fold1[15:0] + {15'd0, fold1[16]};
  assign csum_o = ~fold2;

endmodule

// ==== verilog/roce_hdr_builder.sv ====
`timescale 1ns/1ps

module roce_hdr_builder #(
  parameter int NUM_QP  = 5,
  parameter int QP_BASE = 3
) (
  input  logic                         core_clk,
  input  logic                         core_aresetn,
  input  logic                         build_i,
  input  rdma_resp_gen_pkg::pkt_kind_e kind_i,
  input  rdma_resp_gen_pkg::qpn_t      qpn_i,
  input  rdma_resp_gen_pkg::psn_t      psn_i,
  input  rdma_resp_gen_pkg::mac_t      src_mac_i,
  input  rdma_resp_gen_pkg::ipv4_t     src_ip_i,
  input  rdma_resp_gen_pkg::mac_t      qp_dest_mac_i [NUM_QP],
  input  rdma_resp_gen_pkg::ipv4_t     qp_dest_ip_i [NUM_QP],
  output rdma_resp_gen_pkg::hdr_vec_t  hdr_o
);

  rdma_resp_gen_pkg::mac_t     peer_mac;
  rdma_resp_gen_pkg::ipv4_t    peer_ip;
  logic [15:0]                 total_len;
  logic [15:0]                 udp_len;
  logic [7:0]                  opcode;
  logic [15:0]                 ip_csum;
  rdma_resp_gen_pkg::hdr_vec_t hdr_wire;  // wire order, byte 0 at the top

  function automatic rdma_resp_gen_pkg::hdr_vec_t swap_bytes(
    input rdma_resp_gen_pkg::hdr_vec_t v
  );
    rdma_resp_gen_pkg::hdr_vec_t r;
    for (int b = 0; b < rdma_resp_gen_pkg::HDR_BYTES; b++) begin
      r[b*8 +: 8] = v[(rdma_resp_gen_pkg::HDR_BYTES-1-b)*8 +: 8];
    end
    return r;
  endfunction

  // qp table lookup, table entry 0 is QP_BASE
  always_comb begin
    peer_mac = rdma_resp_gen_pkg::DEFAULT_PEER_MAC;
    peer_ip  = rdma_resp_gen_pkg::DEFAULT_PEER_IP;
    for (int i = 0; i < NUM_QP; i++) begin
      if (qpn_i == rdma_resp_gen_pkg::qpn_t'(QP_BASE + i)) begin
        peer_mac = qp_dest_mac_i[i];
        peer_ip  = qp_dest_ip_i[i];
      end
    end
  end

  always_comb begin
    if (kind_i == rdma_resp_gen_pkg::PKT_RD_RESP) begin
      opcode    = rdma_resp_gen_pkg::BTH_OPC_RD_RESP;
      total_len = rdma_resp_gen_pkg::IP_TOTAL_LEN_RD;
    end else begin
      opcode    = rdma_resp_gen_pkg::BTH_OPC_ACK;
      total_len = rdma_resp_gen_pkg::IP_TOTAL_LEN_ACK;
    end
  end

  assign udp_len = total_len - 16'd20;  // minus ipv4 header

  ipv4_hdr_checksum i_csum (
    .total_len_i (total_len),
    .dst_ip_i    (peer_ip),
    .src_ip_i    (src_ip_i),
    .csum_o      (ip_csum)
  );

  // eth | ipv4 | udp | bth | aeth (zero)
  assign hdr_wire = {
    peer_mac, src_mac_i, rdma_resp_gen_pkg::ETH_TYPE_IPV4,
    rdma_resp_gen_pkg::IP_VER_IHL, rdma_resp_gen_pkg::IP_TOS, total_len,
    rdma_resp_gen_pkg::IP_ID, rdma_resp_gen_pkg::IP_FLAGS,
    rdma_resp_gen_pkg::IP_TTL, rdma_resp_gen_pkg::IP_PROTO_UDP, ip_csum,
    src_ip_i, peer_ip,
    rdma_resp_gen_pkg::UDP_SRC_PORT, rdma_resp_gen_pkg::UDP_DST_PORT, udp_len, 16'h0000,
    opcode, 8'h00, rdma_resp_gen_pkg::BTH_PKEY,
    rdma_resp_gen_pkg::BTH_RSVD, qpn_i,
    8'h00, psn_i,
    32'h0000_0000
  };

  always_ff @(posedge core_clk or negedge core_aresetn) begin
    if (!core_aresetn) begin
      hdr_o <= '0;
    end else if (build_i) begin
      hdr_o <= swap_bytes(hdr_wire);
    end
  end

endmodule

// ==== verilog/axis_beat_serializer.sv ====
`timescale 1ns/1ps

module axis_beat_serializer #(
  parameter int DATA_WIDTH = 512
) (
  input  logic                        core_clk,
  input  logic                        core_aresetn,
  input  logic                        start_i,
  input  rdma_resp_gen_pkg::pkt_vec_t pkt_i,
  input  rdma_resp_gen_pkg::pkt_len_t len_i,
  output logic [DATA_WIDTH-1:0]       tx_tdata_o,
  output logic [DATA_WIDTH/8-1:0]     tx_tkeep_o,
  output logic                        tx_tvalid_o,
  output logic                        tx_tlast_o,
  output logic                        pkt_end_o
);

  localparam int BEAT_B = DATA_WIDTH / 8;

  rdma_resp_gen_pkg::pkt_vec_t pkt_q;
  rdma_resp_gen_pkg::pkt_vec_t cur_pkt;
  rdma_resp_gen_pkg::pkt_len_t rem_q;
  rdma_resp_gen_pkg::pkt_len_t cur_len;
  logic                        busy;
  logic [BEAT_B-1:0]           last_keep;

  // start bypasses the latch so the first beat is not delayed
  assign cur_pkt = start_i ? pkt_i : pkt_q;
  assign cur_len = start_i ? len_i : rem_q;

  always_comb begin
    for (int i = 0; i < BEAT_B; i++) begin
      last_keep[i] = (i < cur_len);  // low bytes of the tail beat
    end
  end

  always_ff @(posedge core_clk) begin
    if (start_i || busy) begin
      pkt_q <= cur_pkt >> DATA_WIDTH;
    end
  end

  always_ff @(posedge core_clk or negedge core_aresetn) begin
    if (!core_aresetn) begin
      busy        <= 1'b0;
      rem_q       <= '0;
      tx_tdata_o  <= '0;
      tx_tkeep_o  <= '0;
      tx_tvalid_o <= 1'b0;
      tx_tlast_o  <= 1'b0;
    end else if (start_i || busy) begin
      tx_tdata_o  <= cur_pkt[DATA_WIDTH-1:0];
      tx_tvalid_o <= 1'b1;
      if (cur_len > rdma_resp_gen_pkg::pkt_len_t'(BEAT_B)) begin
        tx_tkeep_o <= '1;
        tx_tlast_o <= 1'b0;
        rem_q      <= cur_len - rdma_resp_gen_pkg::pkt_len_t'(BEAT_B);
        busy       <= 1'b1;
      end else begin
        tx_tkeep_o <= last_keep;
        tx_tlast_o <= 1'b1;
        rem_q      <= '0;
        busy       <= 1'b0;
      end
    end else begin
      tx_tkeep_o  <= '0;
      tx_tvalid_o <= 1'b0;
      tx_tlast_o  <= 1'b0;
    end
  end

  assign pkt_end_o = tx_tvalid_o & tx_tlast_o;

endmodule

// ==== verilog/rd_wr_test_sequencer.sv ====
`timescale 1ns/1ps

module rd_wr_test_sequencer #(
  parameter int NUM_RD_PKT = 8,
  parameter int NUM_WR_PKT = 8,
  parameter int GAP_CYCLES = 256
) (
  input  logic                                          core_clk,
  input  logic                                          core_aresetn,
  input  logic                                          conf_of_reg_done_i,
  input  logic [rdma_resp_gen_pkg::BEAT_BYTES*8-1:0]    wqe_tdata_i,
  input  logic                                          wqe_tvalid_i,
  input  logic                                          wqe_tlast_i,
  input  logic                                          pkt_end_i,
  output logic                                          post_rd_wqe_o,
  output logic                                          post_wr_wqe_o,
  output logic                                          build_o,
  output logic                                          start_o,
  output rdma_resp_gen_pkg::pkt_kind_e                  kind_o,
  output rdma_resp_gen_pkg::qpn_t                       qpn_o,
  output rdma_resp_gen_pkg::psn_t                       psn_o,
  output logic [15:0]                                   pkt_idx_o,
  output rdma_resp_gen_pkg::pkt_len_t                   len_o,
  output logic                                          rd_path_done_o,
  output logic                                          wr_path_done_o
);

  localparam int GAP_W = $clog2(GAP_CYCLES + 1);

  typedef enum logic [2:0] {
    S_IDLE, S_POST, S_WQE, S_BUILD, S_SEND, S_GAP, S_DONE
  } state_e;

  state_e           state;
  logic             wqe_first;  // next valid beat is the descriptor head
  logic [GAP_W-1:0] gap_cnt;
  logic [15:0]      pkt_cnt;

  assign pkt_idx_o = pkt_cnt;
  assign len_o     = (kind_o == rdma_resp_gen_pkg::PKT_RD_RESP) ?
                     rdma_resp_gen_pkg::pkt_len_t'(rdma_resp_gen_pkg::RD_PKT_BYTES) :
                     rdma_resp_gen_pkg::pkt_len_t'(rdma_resp_gen_pkg::ACK_PKT_BYTES);

  // qp in bytes 47..49, psn in 51..53, msb first
  always_ff @(posedge core_clk) begin
    if (state == S_WQE && wqe_tvalid_i && wqe_first) begin
      qpn_o <= {wqe_tdata_i[47*8 +: 8], wqe_tdata_i[48*8 +: 8], wqe_tdata_i[49*8 +: 8]};
      psn_o <= {wqe_tdata_i[51*8 +: 8], wqe_tdata_i[52*8 +: 8], wqe_tdata_i[53*8 +: 8]};
    end
  end

  always_ff @(posedge core_clk or negedge core_aresetn) begin
    if (!core_aresetn) begin
      state          <= S_IDLE;
      kind_o         <= rdma_resp_gen_pkg::PKT_RD_RESP;
      wqe_first      <= 1'b0;
      gap_cnt        <= '0;
      pkt_cnt        <= '0;
      post_rd_wqe_o  <= 1'b0;
      post_wr_wqe_o  <= 1'b0;
      build_o        <= 1'b0;
      start_o        <= 1'b0;
      rd_path_done_o <= 1'b0;
      wr_path_done_o <= 1'b0;
    end else begin
      post_rd_wqe_o <= 1'b0;
      post_wr_wqe_o <= 1'b0;
      build_o       <= 1'b0;
      start_o       <= 1'b0;
      case (state)
        S_IDLE: begin
          if (conf_of_reg_done_i) state <= S_POST;
        end
        S_POST: begin
          if (conf_of_reg_done_i) begin
            post_rd_wqe_o <= (kind_o == rdma_resp_gen_pkg::PKT_RD_RESP);
            post_wr_wqe_o <= (kind_o == rdma_resp_gen_pkg::PKT_ACK);
            wqe_first     <= 1'b1;
            state         <= S_WQE;
          end
        end
        S_WQE: begin
          if (wqe_tvalid_i) begin
            wqe_first <= 1'b0;
            if (wqe_tlast_i) begin
              build_o <= 1'b1;
              state   <= S_BUILD;
            end
          end
        end
        S_BUILD: begin  // header registers this cycle
          start_o <= 1'b1;
          state   <= S_SEND;
        end
        S_SEND: begin
          if (pkt_end_i) begin
            pkt_cnt <= pkt_cnt + 16'd1;
            gap_cnt <= '0;
            state   <= S_GAP;
          end
        end
        S_GAP: begin
          if (gap_cnt == GAP_W'(GAP_CYCLES - 1)) begin
            state <= S_POST;
            if (kind_o == rdma_resp_gen_pkg::PKT_RD_RESP && pkt_cnt == 16'(NUM_RD_PKT)) begin
              rd_path_done_o <= 1'b1;  // switch to write phase
              kind_o         <= rdma_resp_gen_pkg::PKT_ACK;
              pkt_cnt        <= '0;
            end else if (kind_o == rdma_resp_gen_pkg::PKT_ACK &&
                         pkt_cnt == 16'(NUM_WR_PKT)) begin
              wr_path_done_o <= 1'b1;
              state          <= S_DONE;
            end
          end else begin
            gap_cnt <= gap_cnt + 1'b1;
          end
        end
        S_DONE: state <= S_DONE;
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

// ==== verilog/rdma_resp_gen_top.sv ====
`timescale 1ns/1ps

module rdma_resp_gen_top #(
  parameter int DATA_WIDTH = 512,
  parameter int NUM_QP     = 5,
  parameter int QP_BASE    = 3,
  parameter int NUM_RD_PKT = 8,
  parameter int NUM_WR_PKT = 8,
  parameter int GAP_CYCLES = 256
) (
  input  logic                                       core_clk,
  input  logic                                       core_aresetn,
  input  logic                                       conf_of_reg_done_i,
  input  rdma_resp_gen_pkg::mac_t                    src_mac_i,
  input  rdma_resp_gen_pkg::ipv4_t                   src_ip_i,
  input  rdma_resp_gen_pkg::mac_t                    qp_dest_mac_i [NUM_QP],
  input  rdma_resp_gen_pkg::ipv4_t                   qp_dest_ip_i [NUM_QP],
  input  logic [rdma_resp_gen_pkg::BEAT_BYTES*8-1:0] wqe_tdata_i,
  input  logic                                       wqe_tvalid_i,
  input  logic                                       wqe_tlast_i,
  output logic [DATA_WIDTH-1:0]                      tx_tdata_o,
  output logic [DATA_WIDTH/8-1:0]                    tx_tkeep_o,
  output logic                                       tx_tvalid_o,
  output logic                                       tx_tlast_o,
  output logic                                       post_rd_wqe_o,
  output logic                                       post_wr_wqe_o,
  output logic                                       rd_path_done_o,
  output logic                                       wr_path_done_o
);

  localparam int PAD_BITS = (rdma_resp_gen_pkg::MAX_BEATS * rdma_resp_gen_pkg::BEAT_BYTES
                            - rdma_resp_gen_pkg::RD_PKT_BYTES) * 8;

  logic                                            build;
  logic                                            start;
  logic                                            pkt_end;
  rdma_resp_gen_pkg::pkt_kind_e                    kind;
  rdma_resp_gen_pkg::qpn_t                         qpn;
  rdma_resp_gen_pkg::psn_t                         psn;
  logic [15:0]                                     pkt_idx;
  rdma_resp_gen_pkg::pkt_len_t                     len;
  rdma_resp_gen_pkg::hdr_vec_t                     hdr;
  logic [7:0]                                      pat_byte;
  logic [rdma_resp_gen_pkg::RD_PAYLOAD_BYTES*8-1:0] payload;
  rdma_resp_gen_pkg::pkt_vec_t                     pkt_img;

  assign pat_byte = {4'h1, pkt_idx[3:0] + 4'd1};  // wraps mod 16
  assign payload  = (kind == rdma_resp_gen_pkg::PKT_RD_RESP) ?
                    {rdma_resp_gen_pkg::RD_PAYLOAD_BYTES{pat_byte}} : '0;
  assign pkt_img  = {{PAD_BITS{1'b0}}, payload, hdr};

  rd_wr_test_sequencer #(
    .NUM_RD_PKT (NUM_RD_PKT),
    .NUM_WR_PKT (NUM_WR_PKT),
    .GAP_CYCLES (GAP_CYCLES)
  ) i_seq (
    .core_clk           (core_clk),
    .core_aresetn       (core_aresetn),
    .conf_of_reg_done_i (conf_of_reg_done_i),
    .wqe_tdata_i        (wqe_tdata_i),
    .wqe_tvalid_i       (wqe_tvalid_i),
    .wqe_tlast_i        (wqe_tlast_i),
    .pkt_end_i          (pkt_end),
    .post_rd_wqe_o      (post_rd_wqe_o),
    .post_wr_wqe_o      (post_wr_wqe_o),
    .build_o            (build),
    .start_o            (start),
    .kind_o             (kind),
    .qpn_o              (qpn),
    .psn_o              (psn),
    .pkt_idx_o          (pkt_idx),
    .len_o              (len),
    .rd_path_done_o     (rd_path_done_o),
    .wr_path_done_o     (wr_path_done_o)
  );

  roce_hdr_builder #(
    .NUM_QP  (NUM_QP),
    .QP_BASE (QP_BASE)
  ) i_hdr (
    .core_clk      (core_clk),
    .core_aresetn  (core_aresetn),
    .build_i       (build),
    .kind_i        (kind),
    .qpn_i         (qpn),
    .psn_i         (psn),
    .src_mac_i     (src_mac_i),
    .src_ip_i      (src_ip_i),
    .qp_dest_mac_i (qp_dest_mac_i),
    .qp_dest_ip_i  (qp_dest_ip_i),
    .hdr_o         (hdr)
  );

  axis_beat_serializer #(
    .DATA_WIDTH (DATA_WIDTH)
  ) i_ser (
    .core_clk     (core_clk),
    .core_aresetn (core_aresetn),
    .start_i      (start),
    .pkt_i        (pkt_img),
    .len_i        (len),
    .tx_tdata_o   (tx_tdata_o),
    .tx_tkeep_o   (tx_tkeep_o),
    .tx_tvalid_o  (tx_tvalid_o),
    .tx_tlast_o   (tx_tlast_o),
    .pkt_end_o    (pkt_end)
  );

endmodule

// ==== test/tb_rdma_resp_gen.sv ====
`timescale 1ns/1ps

module tb_rdma_resp_gen;

  localparam int NUM_QP      = 5;
  localparam int QP_BASE     = 3;
  localparam int NUM_RD_PKT  = 3;
  localparam int NUM_WR_PKT  = 3;
  localparam int GAP_CYCLES  = 16;
  localparam int ROWS        = NUM_RD_PKT + NUM_WR_PKT;
  localparam int CONF_DELAY  = 10;
  localparam int TAIL_CYC    = 2 * GAP_CYCLES;
  localparam int TIMEOUT_CYC = 3 + CONF_DELAY + ROWS * (8 + 2 + 5 + GAP_CYCLES + 20) + TAIL_CYC;

  // qp 2 is below the table and maps to the default peer
  localparam logic [23:0] ROW_QPN [ROWS] = '{24'd2, 24'd3, 24'd4, 24'd5, 24'd6, 24'd7};
  localparam logic [23:0] ROW_PSN [ROWS] = '{24'h000001, 24'h00abcd, 24'hfffffe,
                                             24'h123456, 24'h800000, 24'h7fffff};
  localparam rdma_resp_gen_pkg::pkt_kind_e ROW_KIND [ROWS] = '{
    rdma_resp_gen_pkg::PKT_RD_RESP, rdma_resp_gen_pkg::PKT_RD_RESP, rdma_resp_gen_pkg::PKT_RD_RESP,
    rdma_resp_gen_pkg::PKT_ACK, rdma_resp_gen_pkg::PKT_ACK, rdma_resp_gen_pkg::PKT_ACK
  };

  logic                     core_clk = 1'b0;
  logic                     core_aresetn;
  logic                     conf_of_reg_done_i;
  rdma_resp_gen_pkg::mac_t  src_mac_i;
  rdma_resp_gen_pkg::ipv4_t src_ip_i;
  rdma_resp_gen_pkg::mac_t  qp_dest_mac_i [NUM_QP];
  rdma_resp_gen_pkg::ipv4_t qp_dest_ip_i [NUM_QP];
  logic [511:0]             wqe_tdata_i;
  logic                     wqe_tvalid_i;
  logic                     wqe_tlast_i;
  logic [511:0]             tx_tdata_o;
  logic [63:0]              tx_tkeep_o;
  logic                     tx_tvalid_o;
  logic                     tx_tlast_o;
  logic                     post_rd_wqe_o;
  logic                     post_wr_wqe_o;
  logic                     rd_path_done_o;
  logic                     wr_path_done_o;

  int          errors    = 0;
  int          post_cnt  = 0;
  int          pkt_cnt   = 0;  // packets completed
  int          rd_cnt    = 0;  // read responses completed
  int          beat_idx  = 0;
  logic        rd_done_q = 1'b0;
  logic        wr_done_q = 1'b0;
  logic [31:0] rng_state;

  always #4 core_clk = ~core_clk;

  rdma_resp_gen_top #(
    .DATA_WIDTH (512),
    .NUM_QP     (NUM_QP),
    .QP_BASE    (QP_BASE),
    .NUM_RD_PKT (NUM_RD_PKT),
    .NUM_WR_PKT (NUM_WR_PKT),
    .GAP_CYCLES (GAP_CYCLES)
  ) i_dut (
    .core_clk           (core_clk),
    .core_aresetn       (core_aresetn),
    .conf_of_reg_done_i (conf_of_reg_done_i),
    .src_mac_i          (src_mac_i),
    .src_ip_i           (src_ip_i),
    .qp_dest_mac_i      (qp_dest_mac_i),
    .qp_dest_ip_i       (qp_dest_ip_i),
    .wqe_tdata_i        (wqe_tdata_i),
    .wqe_tvalid_i       (wqe_tvalid_i),
    .wqe_tlast_i        (wqe_tlast_i),
    .tx_tdata_o         (tx_tdata_o),
    .tx_tkeep_o         (tx_tkeep_o),
    .tx_tvalid_o        (tx_tvalid_o),
    .tx_tlast_o         (tx_tlast_o),
    .post_rd_wqe_o      (post_rd_wqe_o),
    .post_wr_wqe_o      (post_wr_wqe_o),
    .rd_path_done_o     (rd_path_done_o),
    .wr_path_done_o     (wr_path_done_o)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] r;
    r = s ^ (s << 13);
    r = r ^ (r >> 17);
    r = r ^ (r << 5);
    return r;
  endfunction

  // qp in bytes 47..49 and psn in 51..53 over filler bytes holding their index
  function automatic logic [511:0] make_desc(input logic [23:0] qpn, input logic [23:0] psn);
    logic [511:0] d;
    for (int i = 0; i < 64; i++) d[i*8 +: 8] = 8'(i);
    d[47*8 +: 8] = qpn[23:16];
    d[48*8 +: 8] = qpn[15:8];
    d[49*8 +: 8] = qpn[7:0];
    d[51*8 +: 8] = psn[23:16];
    d[52*8 +: 8] = psn[15:8];
    d[53*8 +: 8] = psn[7:0];
    return d;
  endfunction

  // field in network order with the first byte most significant
  function automatic logic [63:0] wire_field(input logic [511:0] d, input int first,
                                             input int nbytes);
    logic [63:0] r;
    r = '0;
    for (int k = 0; k < nbytes; k++) r = (r << 8) | 64'(d[(first+k)*8 +: 8]);
    return r;
  endfunction

  task automatic compare_field(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    if (got !== exp) begin
      $display("MISMATCH t=%0t %s expected=%0h got=%0h", $time, name, exp, got);
      errors++;
    end
  endtask

  task automatic check_header(input logic [511:0] d, input int row);
    logic [23:0] qpn;
    logic [47:0] exp_mac;
    logic [31:0] exp_ip;
    logic [15:0] exp_len;
    logic [7:0]  exp_opc;
    logic [31:0] sum;
    qpn = ROW_QPN[row];
    if (qpn >= QP_BASE && qpn < QP_BASE + NUM_QP) begin
      exp_mac = qp_dest_mac_i[qpn - QP_BASE];
      exp_ip  = qp_dest_ip_i[qpn - QP_BASE];
    end else begin
      exp_mac = rdma_resp_gen_pkg::DEFAULT_PEER_MAC;
      exp_ip  = rdma_resp_gen_pkg::DEFAULT_PEER_IP;
    end
    exp_opc = (ROW_KIND[row] == rdma_resp_gen_pkg::PKT_RD_RESP) ? 8'h10 : 8'h11;
    exp_len = (ROW_KIND[row] == rdma_resp_gen_pkg::PKT_RD_RESP) ? 16'h0130 : 16'h0030;
    compare_field("tx_tdata_o.dst_mac", wire_field(d, 0, 6), exp_mac);
    compare_field("tx_tdata_o.src_mac", wire_field(d, 6, 6), src_mac_i);
    compare_field("tx_tdata_o.eth_type", wire_field(d, 12, 2), 16'h0800);
    compare_field("tx_tdata_o.ip_total_len", wire_field(d, 16, 2), exp_len);
    compare_field("tx_tdata_o.src_ip", wire_field(d, 26, 4), src_ip_i);
    compare_field("tx_tdata_o.dst_ip", wire_field(d, 30, 4), exp_ip);
    compare_field("tx_tdata_o.udp_dst_port", wire_field(d, 36, 2), 16'h12b7);
    compare_field("tx_tdata_o.udp_len", wire_field(d, 38, 2), exp_len - 16'd20);
    compare_field("tx_tdata_o.bth_opcode", wire_field(d, 42, 1), exp_opc);
    compare_field("tx_tdata_o.bth_qpn", wire_field(d, 47, 3), qpn);
    compare_field("tx_tdata_o.bth_psn", wire_field(d, 51, 3), ROW_PSN[row]);
    sum = '0;
    for (int w = 0; w < 10; w++) sum = sum + 32'(wire_field(d, 14 + 2*w, 2));
    repeat (2) sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};
    compare_field("tx_tdata_o.ipv4_csum_sum", sum[15:0], 16'hffff);
  endtask

  task automatic check_payload(input logic [511:0] d, input int beat, input int n);
    logic [7:0] exp;
    int         off;
    exp = 8'h10 + 8'((n + 1) % 16);
    for (int i = 0; i < 64; i++) begin
      off = beat * 64 + i;
      if (off >= 58 && off < 314 && d[i*8 +: 8] !== exp) begin
        $display("MISMATCH t=%0t tx_tdata_o payload byte %0d expected=%0h got=%0h",
                 $time, off - 58, exp, d[i*8 +: 8]);
        errors++;
        break;
      end
    end
  endtask

  // descriptor peer answers each post pulse with the next table row
  initial begin : peer_model
    int row;
    int wait_cyc;
    row = 0;
    rng_state = 32'h21fac8ba;
    forever begin
      @(negedge core_clk);
      if ((post_rd_wqe_o || post_wr_wqe_o) && row < ROWS) begin
        rng_state = xorshift32(rng_state);
        wait_cyc  = 1 + int'(rng_state % 8);
        repeat (wait_cyc) @(posedge core_clk);
        wqe_tdata_i  <= make_desc(ROW_QPN[row], ROW_PSN[row]);
        wqe_tvalid_i <= 1'b1;
        wqe_tlast_i  <= 1'b0;
        @(posedge core_clk);
        wqe_tdata_i <= make_desc(~ROW_QPN[row], ~ROW_PSN[row]);  // must not be captured
        wqe_tlast_i <= 1'b1;
        @(posedge core_clk);
        wqe_tdata_i  <= '0;
        wqe_tvalid_i <= 1'b0;
        wqe_tlast_i  <= 1'b0;
        row++;
      end
    end
  end

  always @(negedge core_clk) begin : monitor
    int          pkt_len;
    int          n_beats;
    logic        is_last;
    logic [63:0] exp_keep;
    if (!core_aresetn) begin
      if (tx_tvalid_o || tx_tlast_o || |tx_tkeep_o || |tx_tdata_o ||
          post_rd_wqe_o || post_wr_wqe_o || rd_path_done_o || wr_path_done_o) begin
        $display("outputs are not low during reset at t=%0t", $time);
        errors++;
      end
    end else begin
      if (post_rd_wqe_o || post_wr_wqe_o) begin
        if (!conf_of_reg_done_i) begin
          $display("post pulse before configuration done at t=%0t", $time);
          errors++;
        end
        if (post_cnt >= ROWS) begin
          $display("extra post pulse after the last table row at t=%0t", $time);
          errors++;
        end else begin
          compare_field("post_rd_wqe_o", post_rd_wqe_o,
                        ROW_KIND[post_cnt] == rdma_resp_gen_pkg::PKT_RD_RESP);
          compare_field("post_wr_wqe_o", post_wr_wqe_o,
                        ROW_KIND[post_cnt] == rdma_resp_gen_pkg::PKT_ACK);
          if (post_wr_wqe_o && !rd_path_done_o) begin
            $display("write post before rd_path_done_o at t=%0t", $time);
            errors++;
          end
        end
        post_cnt++;
      end
      if (rd_done_q && !rd_path_done_o) begin
        $display("rd_path_done_o dropped at t=%0t", $time);
        errors++;
      end
      if (wr_done_q && !wr_path_done_o) begin
        $display("wr_path_done_o dropped at t=%0t", $time);
        errors++;
      end
      if (rd_path_done_o && !rd_done_q) compare_field("read responses at rd_path_done_o",
                                                      rd_cnt, NUM_RD_PKT);
      if (wr_path_done_o && !wr_done_q) compare_field("packets at wr_path_done_o",
                                                      pkt_cnt, ROWS);
      rd_done_q = rd_path_done_o;
      wr_done_q = wr_path_done_o;
      if (tx_tvalid_o) begin
        if (pkt_cnt >= ROWS) begin
          $display("tx beat after the last packet at t=%0t", $time);
          errors++;
        end else begin
          pkt_len  = (ROW_KIND[pkt_cnt] == rdma_resp_gen_pkg::PKT_RD_RESP) ? 314 : 58;
          n_beats  = (pkt_len + 63) / 64;
          is_last  = (beat_idx == n_beats - 1);
          exp_keep = is_last ? ((64'd1 << (pkt_len - 64 * (n_beats - 1))) - 64'd1) : '1;
          if (beat_idx == 0) check_header(tx_tdata_o, pkt_cnt);
          compare_field("tx_tkeep_o", tx_tkeep_o, exp_keep);
          compare_field("tx_tlast_o", tx_tlast_o, is_last);
          if (ROW_KIND[pkt_cnt] == rdma_resp_gen_pkg::PKT_RD_RESP) begin
            check_payload(tx_tdata_o, beat_idx, rd_cnt);
          end
          if (is_last) begin
            if (ROW_KIND[pkt_cnt] == rdma_resp_gen_pkg::PKT_RD_RESP) rd_cnt++;
            beat_idx = 0;
            pkt_cnt++;
          end else begin
            beat_idx++;
          end
        end
      end else if (beat_idx != 0) begin
        $display("tx_tvalid_o dropped inside a packet at t=%0t", $time);
        errors++;
        beat_idx = 0;
        pkt_cnt++;
      end
    end
  end

  initial begin : watchdog
    #(TIMEOUT_CYC * 8);
    $display("timeout after %0d cycles, the run did not complete", TIMEOUT_CYC);
    $display("Testbench failed");
    $finish;
  end

  initial begin : main
    core_aresetn       = 1'b0;
    conf_of_reg_done_i = 1'b0;
    src_mac_i          = 48'h0a1b2c3d4e5f;
    src_ip_i           = 32'hc0a80a01;
    wqe_tdata_i        = '0;
    wqe_tvalid_i       = 1'b0;
    wqe_tlast_i        = 1'b0;
    for (int i = 0; i < NUM_QP; i++) begin
      qp_dest_mac_i[i] = 48'h02005e000010 + 48'(i);
      qp_dest_ip_i[i]  = 32'h0a000064 + 32'(i);
    end
    repeat (3) @(posedge core_clk);
    core_aresetn <= 1'b1;
    repeat (CONF_DELAY) @(posedge core_clk);  // no traffic expected yet
    conf_of_reg_done_i <= 1'b1;
    while (!wr_path_done_o) @(posedge core_clk);
    repeat (TAIL_CYC) @(posedge core_clk);
    compare_field("post count", post_cnt, ROWS);
    compare_field("packet count", pkt_cnt, ROWS);
    compare_field("rd_path_done_o", rd_path_done_o, 1'b1);
    $display("errors: %0d  posts: %0d  packets: %0d", errors, post_cnt, pkt_cnt);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== rdma_resp_gen.f ====
verilog/rdma_resp_gen_pkg.sv
verilog/ipv4_hdr_checksum.sv
verilog/roce_hdr_builder.sv
verilog/axis_beat_serializer.sv
verilog/rd_wr_test_sequencer.sv
verilog/rdma_resp_gen_top.sv
test/tb_rdma_resp_gen.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_rdma_resp_gen \
  -f rdma_resp_gen.f -o tb_rdma_resp_gen_sim

./obj_dir/tb_rdma_resp_gen_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Testbench passed" sim.log; then
  exit 0
fi
exit 1
